/* falling_spikes_obstacle.f */
+incdir+include
src/video_pkg.sv
src/spike_pkg.sv
src/spike_sequencer.sv
src/spike_timer.sv
src/spike_position.sv
src/spike_renderer.sv
src/falling_spikes_obstacle.sv
test/spike_checker.sv
test/tb_falling_spikes.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log for failures
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_falling_spikes \
    -f falling_spikes_obstacle.f -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && { echo "RESULT: FAIL"; exit 1; } \
    || { echo "RESULT: PASS"; exit 0; }

/* test/tb_falling_spikes.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spike_params.svh"

module tb_falling_spikes;
    import video_pkg::*;
    import spike_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int FALL_STEPS  = int'(`FIELD_BOTTOM) - int'(`FIELD_TOP) - int'(`SPIKE_HALF_WIDTH);
    // load, aim, fall steps, then the cycle in which landing is seen
    localparam int BASE_SLOW   = 1 + int'(`AIM_TICKS) + FALL_STEPS * int'(`STEP_SLOW) + 1;
    localparam int BASE_FAST   = 1 + int'(`AIM_TICKS) + FALL_STEPS * int'(`STEP_FAST) + 1;
    localparam int LONGEST     = BASE_SLOW + int'(`SETTLE_TICKS);
    // five of each kind, only plain top spikes settle
    localparam int SEQ_CYCLES  = 5 * LONGEST + 5 * BASE_SLOW + 10 * BASE_FAST;
    localparam int WATCHDOG    = 2 * int'(`SPIKE_COUNT) * LONGEST + 5000;
    localparam int MOUSE_RANGE = int'(`AIM_TICKS) / int'(`STEP_SLOW);

    logic       clk;
    logic       rst;
    logic       done_in;
    logic       play_selected;
    logic       menu_on;
    logic [2:0] selected;
    coord_t     hcount;
    coord_t     vcount;
    coord_t     mouse_xpos;
    rgb_t       rgb_in;
    rgb_t       rgb_out;
    coord_t     obstacle_x;
    coord_t     obstacle_y;
    logic       done;
    seq_state_t model_state;
    int         model_cx;
    int         model_cy;
    int         check_count;
    int         error_count;
    int         done_count;
    int         seed;
    int         tb_errors;
    int         dones_before;

    falling_spikes_obstacle DUT (
        .clk (clk), .rst (rst), .done_in (done_in), .play_selected (play_selected),
        .menu_on (menu_on), .selected (selected), .hcount (hcount), .vcount (vcount),
        .mouse_xpos (mouse_xpos), .rgb_in (rgb_in), .rgb_out (rgb_out),
        .obstacle_x (obstacle_x), .obstacle_y (obstacle_y), .done (done)
    );

    spike_checker u_checker (
        .clk (clk), .rst (rst), .done_in (done_in), .play_selected (play_selected),
        .menu_on (menu_on), .selected (selected), .hcount (hcount), .vcount (vcount),
        .mouse_xpos (mouse_xpos), .rgb_in (rgb_in), .rgb_out (rgb_out),
        .obstacle_x (obstacle_x), .obstacle_y (obstacle_y), .done (done),
        .model_state (model_state), .model_cx (model_cx), .model_cy (model_cy),
        .check_count (check_count), .error_count (error_count), .done_count (done_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // run limit covers two full attacks plus the idle tests
    initial begin
        #(WATCHDOG * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
        $display("Test failures found");
        $finish;
    end

    // half the pixels land near the spike so the triangle gets hit often
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if ({$random(seed)} % 2 == 0) begin
            hcount = coord_t'(341 + {$random(seed)} % 341);
            vcount = coord_t'(297 + {$random(seed)} % 341);
        end else begin
            hcount = coord_t'(model_cx - 24 + {$random(seed)} % 49);
            vcount = coord_t'(model_cy - 56 + {$random(seed)} % 113);
        end
        rgb_in = rgb_t'($random(seed));
        // new mouse column per spike, held through its aim phase
        if (model_state == seq_load) begin
            mouse_xpos = coord_t'(int'(`FIELD_CENTER_X) - MOUSE_RANGE +
                                  {$random(seed)} % (2 * MOUSE_RANGE + 1));
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic start_attack(input logic [2:0] code);
        selected = code;
        done_in  = 1'b1;
        next_cycle();
        done_in  = 1'b0;
    endtask

    // cycles counted from the first load cycle
    task automatic wait_for_done(input int expected);
        int cycles;
        cycles = 1;
        while ((done !== 1'b1) && (cycles <= 20 * LONGEST)) begin
            next_cycle();
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("done pulse never came within %0d cycles of the start", cycles);
            tb_errors++;
        end else if (cycles != expected) begin
            $display("[ERROR] t=%0t done cycle expected %0d got %0d", $time, expected, cycles);
            tb_errors++;
        end
    endtask

    task automatic wait_for_fall(input int limit);
        int cycles;
        cycles = 0;
        while ((model_state != seq_fall) && (cycles < limit)) begin
            next_cycle();
            cycles++;
        end
        if (model_state != seq_fall) begin
            $display("attack never reached a fall phase within %0d cycles", limit);
            tb_errors++;
        end
    endtask

    task automatic check_done_pulses(input int expected, input string phase);
        if (done_count - dones_before != expected) begin
            $display("[ERROR] t=%0t done pulses in %s expected %0d got %0d",
                     $time, phase, expected, done_count - dones_before);
            tb_errors++;
        end
    endtask

    initial begin
        seed          = 32'he2f10e66;
        tb_errors     = 0;
        dones_before  = 0;
        rst           = 1'b1;
        done_in       = 1'b0;
        play_selected = 1'b1;
        menu_on       = 1'b0;
        selected      = `OBSTACLE_CODE;
        hcount        = '0;
        vcount        = '0;
        mouse_xpos    = `FIELD_CENTER_X;
        rgb_in        = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle passthrough
        run_cycles(200);

        // another obstacle code must not start the attack
        start_attack(3'b010);
        run_cycles(200);

        // full attack of 20 spikes
        dones_before = done_count;
        start_attack(`OBSTACLE_CODE);
        wait_for_done(SEQ_CYCLES + 1);
        run_cycles(50);
        check_done_pulses(1, "full sequence");

        // menu during a fall drops the attack
        dones_before = done_count;
        start_attack(`OBSTACLE_CODE);
        wait_for_fall(2 * LONGEST);
        run_cycles(100);
        menu_on = 1'b1;
        next_cycle();
        menu_on = 1'b0;
        // long enough for the dropped attack to have ended on its own
        run_cycles(SEQ_CYCLES);
        check_done_pulses(0, "aborted sequence");

        $display("checks: %0d, errors: %0d", check_count, error_count + tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/spike_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spike_params.svh"

module spike_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  done_in,
    input  logic                  play_selected,
    input  logic                  menu_on,
    input  logic [2:0]            selected,
    input  video_pkg::coord_t     hcount,
    input  video_pkg::coord_t     vcount,
    input  video_pkg::coord_t     mouse_xpos,
    input  video_pkg::rgb_t       rgb_in,
    input  video_pkg::rgb_t       rgb_out,
    input  video_pkg::coord_t     obstacle_x,
    input  video_pkg::coord_t     obstacle_y,
    input  logic                  done,
    output spike_pkg::seq_state_t model_state,
    output int                    model_cx,
    output int                    model_cy,
    output int                    check_count,
    output int                    error_count,
    output int                    done_count
);
    import video_pkg::*;
    import spike_pkg::*;

    localparam int TOP       = int'(`FIELD_TOP);
    localparam int BOTTOM    = int'(`FIELD_BOTTOM);
    localparam int LEFT      = int'(`FIELD_LEFT);
    localparam int RIGHT     = int'(`FIELD_RIGHT);
    localparam int CENTER_X  = int'(`FIELD_CENTER_X);
    localparam int HALF_W    = int'(`SPIKE_HALF_WIDTH);
    localparam int LENGTH    = int'(`SPIKE_LENGTH);
    localparam int TIP       = int'(`SPIKE_TIP);
    localparam int AIM       = int'(`AIM_TICKS);
    localparam int SETTLE    = int'(`SETTLE_TICKS);
    localparam int SLOW_STEP = int'(`STEP_SLOW);
    localparam int FAST_STEP = int'(`STEP_FAST);

    // launch order, bit n set when spike n starts at the bottom edge
    localparam logic [19:0] BOTTOM_MASK  = 20'hAACA6;
    // bit n set when spike n is a barrage
    localparam logic [19:0] BARRAGE_MASK = 20'h3678A;

    seq_state_t state;
    seq_state_t state_before;
    logic [4:0] index;
    int         cx;
    int         cy;
    int         cyc;
    int         aim_x;
    int         step;
    logic       up;
    logic       barrage;
    logic       tick;
    logic       spike_end;
    logic       lit;
    // expected DUT outputs after the coming rising edge
    logic       exp_valid = 1'b0;
    logic       exp_fall;
    logic       exp_done;
    rgb_t       exp_rgb;
    coord_t     exp_x;
    coord_t     exp_y;
    int         checks = 0;
    int         errors = 0;
    int         dones  = 0;

    assign model_state = state;
    assign model_cx    = cx;
    assign model_cy    = cy;
    assign check_count = checks;
    assign error_count = errors;
    assign done_count  = dones;

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("[ERROR] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    // mouse column held inside the aim range
    function automatic int clamp_column(input int x);
        if (x < LEFT) begin
            return LEFT;
        end
        return (x > RIGHT) ? RIGHT : x;
    endfunction

    // triangle rule, depth counted from the center into the field
    function automatic logic pixel_in_spike(input int h, input int v, input int c_x,
                                            input int c_y, input logic from_bottom);
        int dx;
        int dy;
        dx = (h > c_x) ? h - c_x : c_x - h;
        dy = from_bottom ? c_y - v : v - c_y;
        return (dx <= HALF_W) && (dy >= 0) && (dy <= LENGTH) && (3 * dx + dy <= TIP);
    endfunction

    ////////////////////////////////////////
    // compare, then advance the model
    ////////////////////////////////////////
    always @(negedge clk) begin
        // outputs here come from the last rising edge
        if (exp_valid) begin
            check_value("rgb_out", int'(exp_rgb), int'(rgb_out));
            check_value("obstacle_x", int'(exp_x), int'(obstacle_x));
            check_value("obstacle_y", int'(exp_y), int'(obstacle_y));
            check_value("done", int'(exp_done), int'(done));
            if (done === 1'b1) begin
                dones++;
            end
            // lit pixels of a falling spike stay on the aimed column
            if (exp_fall && (obstacle_x != '0)) begin
                checks++;
                if ((int'(obstacle_x) > aim_x + HALF_W) || (int'(obstacle_x) < aim_x - HALF_W)) begin
                    errors++;
                    $display("[ERROR] t=%0t obstacle_x expected within %0d of %0h got %0h",
                             $time, HALF_W, aim_x, obstacle_x);
                end
            end
        end

        if (rst) begin
            state     = seq_idle;
            index     = '0;
            cx        = CENTER_X;
            cy        = TOP;
            cyc       = 0;
            aim_x     = CENTER_X;
            exp_rgb   = '0;
            exp_x     = '0;
            exp_y     = '0;
            exp_done  = 1'b0;
            exp_fall  = 1'b0;
            exp_valid = 1'b1;
        end else if (exp_valid) begin
            up      = BOTTOM_MASK[index];
            barrage = BARRAGE_MASK[index];
            step    = barrage ? FAST_STEP : SLOW_STEP;

            // pixel seen now is drawn with the current phase and center
            lit = ((state == seq_aim) || (state == seq_fall)) &&
                  pixel_in_spike(int'(hcount), int'(vcount), cx, cy, up);
            if (lit) begin
                exp_rgb = (barrage && (state == seq_aim)) ? `COLOR_WARN : `COLOR_SPIKE;
                exp_x   = hcount;
                exp_y   = vcount;
            end else begin
                exp_rgb = rgb_in;
                exp_x   = '0;
                exp_y   = '0;
            end
            exp_fall = (state == seq_fall);

            state_before = state;
            exp_done     = 1'b0;
            spike_end    = 1'b0;
            // one step every STEP cycles, counted from the phase start
            tick         = ((cyc + 1) % step) == 0;
            case (state)
                seq_idle: begin
                    if (done_in && play_selected && (selected == `OBSTACLE_CODE)) begin
                        state = seq_load;
                        index = '0;
                    end
                end
                seq_load: begin
                    cx    = CENTER_X;
                    cy    = up ? BOTTOM : TOP;
                    cyc   = 0;
                    state = seq_aim;
                end
                seq_aim: begin
                    if (tick && (cx < clamp_column(int'(mouse_xpos)))) begin
                        cx++;
                    end else if (tick && (cx > clamp_column(int'(mouse_xpos)))) begin
                        cx--;
                    end
                    cyc++;
                    if (cyc == AIM) begin
                        aim_x = clamp_column(int'(mouse_xpos));
                        cyc   = 0;
                        state = seq_fall;
                    end
                end
                seq_fall: begin
                    // landing is seen one cycle after the last fall step
                    if (up ? (cy <= TOP + HALF_W) : (cy >= BOTTOM - HALF_W)) begin
                        if (!up && !barrage) begin
                            cyc   = 0;
                            state = seq_settle;
                        end else begin
                            spike_end = 1'b1;
                        end
                    end else begin
                        if (tick) begin
                            cy = up ? cy - 1 : cy + 1;
                        end
                        cyc++;
                    end
                end
                seq_settle: begin
                    cyc++;
                    spike_end = (cyc == SETTLE);
                end
                default: state = seq_idle;
            endcase

            if (spike_end && (index == 5'd19)) begin
                state    = seq_idle;
                exp_done = 1'b1;
            end else if (spike_end) begin
                index++;
                state = seq_load;
            end

            // menu or leaving play drops any running attack
            if ((menu_on || !play_selected) && (state_before != seq_idle)) begin
                state    = seq_idle;
                exp_done = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/falling_spikes_obstacle.sv */
`timescale 1ns/10ps
`default_nettype none

module falling_spikes_obstacle (
    input  logic              clk,
    input  logic              rst,
    input  logic              done_in,
    input  logic              play_selected,
    input  logic              menu_on,
    input  logic [2:0]        selected,
    input  video_pkg::coord_t hcount,
    input  video_pkg::coord_t vcount,
    input  video_pkg::coord_t mouse_xpos,
    input  video_pkg::rgb_t   rgb_in,
    output video_pkg::rgb_t   rgb_out,
    output video_pkg::coord_t obstacle_x,
    output video_pkg::coord_t obstacle_y,
    output logic              done
);
    import video_pkg::*;

    // phase levels and pulses from the sequencer
    logic   load_spike;
    logic   aiming;
    logic   falling;
    logic   settling;
    logic   from_bottom;
    logic   barrage;
    // timer strobes
    logic   step_tick;
    logic   aim_done;
    logic   settle_done;
    // spike geometry
    coord_t center_x;
    coord_t center_y;
    logic   landed;

    spike_sequencer u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .done_in       (done_in),
        .play_selected (play_selected),
        .menu_on       (menu_on),
        .selected      (selected),
        .aim_done      (aim_done),
        .settle_done   (settle_done),
        .landed        (landed),
        .load_spike    (load_spike),
        .aiming        (aiming),
        .falling       (falling),
        .settling      (settling),
        .from_bottom   (from_bottom),
        .barrage       (barrage),
        .done          (done)
    );

    spike_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .aiming      (aiming),
        .falling     (falling),
        .settling    (settling),
        .barrage     (barrage),
        .step_tick   (step_tick),
        .aim_done    (aim_done),
        .settle_done (settle_done)
    );

    spike_position u_position (
        .clk         (clk),
        .rst         (rst),
        .load_spike  (load_spike),
        .aiming      (aiming),
        .falling     (falling),
        .from_bottom (from_bottom),
        .step_tick   (step_tick),
        .mouse_xpos  (mouse_xpos),
        .center_x    (center_x),
        .center_y    (center_y),
        .landed      (landed)
    );

    spike_renderer u_renderer (
        .clk         (clk),
        .rst         (rst),
        .hcount      (hcount),
        .vcount      (vcount),
        .center_x    (center_x),
        .center_y    (center_y),
        .rgb_in      (rgb_in),
        .aiming      (aiming),
        .falling     (falling),
        .from_bottom (from_bottom),
        .barrage     (barrage),
        .rgb_out     (rgb_out),
        .obstacle_x  (obstacle_x),
        .obstacle_y  (obstacle_y)
    );

endmodule

`default_nettype wire

/* src/spike_renderer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spike_params.svh"

module spike_renderer (
    input  logic              clk,
    input  logic              rst,
    input  video_pkg::coord_t hcount,
    input  video_pkg::coord_t vcount,
    input  video_pkg::coord_t center_x,
    input  video_pkg::coord_t center_y,
    input  video_pkg::rgb_t   rgb_in,
    input  logic              aiming,
    input  logic              falling,
    input  logic              from_bottom,
    input  logic              barrage,
    output video_pkg::rgb_t   rgb_out,
    output video_pkg::coord_t obstacle_x,
    output video_pkg::coord_t obstacle_y
);
    import video_pkg::*;

    coord_t      dx;
    coord_t      dy;
    logic        in_front;
    logic        in_box;
    logic [13:0] tri_sum;
    logic        lit;
    rgb_t        spike_color;

    ////////////////////////////////////////
    // offsets from the spike center
    ////////////////////////////////////////
    always_comb begin
        if (hcount >= center_x) begin
            dx = hcount - center_x;
        end else begin
            dx = center_x - hcount;
        end
        // depth grows into the field from the launch side
        if (from_bottom) begin
            in_front = (vcount <= center_y);
            dy       = center_y - vcount;
        end else begin
            in_front = (vcount >= center_y);
            dy       = vcount - center_y;
        end
    end

    // wide enough for 3*dx + dy at full coordinate range
    assign tri_sum = 14'(dx) * 14'd3 + 14'(dy);
    assign in_box  = in_front && (dx <= `SPIKE_HALF_WIDTH) && (dy <= `SPIKE_LENGTH);
    // spike only shows while it aims or falls
    assign lit     = (aiming || falling) && in_box && (tri_sum <= 14'(`SPIKE_TIP));

    // barrage warns in red until it drops
    assign spike_color = (barrage && aiming) ? `COLOR_WARN : `COLOR_SPIKE;

    // one cycle pixel pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_out    <= '0;
            obstacle_x <= '0;
            obstacle_y <= '0;
        end else begin
            rgb_out    <= lit ? spike_color : rgb_in;
            obstacle_x <= lit ? hcount : '0;
            obstacle_y <= lit ? vcount : '0;
        end
    end

endmodule

`default_nettype wire

/* src/spike_position.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spike_params.svh"

module spike_position (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_spike,
    input  logic              aiming,
    input  logic              falling,
    input  logic              from_bottom,
    input  logic              step_tick,
    input  video_pkg::coord_t mouse_xpos,
    output video_pkg::coord_t center_x,
    output video_pkg::coord_t center_y,
    output logic              landed
);
    import video_pkg::*;

    coord_t target_x;
    coord_t launch_y;

    // mouse column limited to the aim range
    always_comb begin
        if (mouse_xpos < `FIELD_LEFT) begin
            target_x = `FIELD_LEFT;
        end else if (mouse_xpos > `FIELD_RIGHT) begin
            target_x = `FIELD_RIGHT;
        end else begin
            target_x = mouse_xpos;
        end
    end

    // spike sits on its own edge before the fall
    assign launch_y = from_bottom ? `FIELD_BOTTOM : `FIELD_TOP;

    ////////////////////////////////////////
    // center registers
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            center_x <= `FIELD_CENTER_X;
            center_y <= `FIELD_TOP;
        end else if (load_spike) begin
            center_x <= `FIELD_CENTER_X;
            center_y <= launch_y;
        end else if (aiming && step_tick) begin
            // one pixel toward the mouse, hold once on target
            if (center_x < target_x) begin
                center_x <= center_x + 12'd1;
            end else if (center_x > target_x) begin
                center_x <= center_x - 12'd1;
            end
        end else if (falling && step_tick) begin
            // straight crossing, column frozen
            if (from_bottom) begin
                center_y <= center_y - 12'd1;
            end else begin
                center_y <= center_y + 12'd1;
            end
        end
    end

    // far edge reached, within one half width
    assign landed = from_bottom ? (center_y <= `FIELD_TOP + `SPIKE_HALF_WIDTH)
                                : (center_y >= `FIELD_BOTTOM - `SPIKE_HALF_WIDTH);

endmodule

`default_nettype wire

/* src/spike_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spike_params.svh"

module spike_timer (
    input  logic clk,
    input  logic rst,
    input  logic aiming,
    input  logic falling,
    input  logic settling,
    input  logic barrage,
    output logic step_tick,
    output logic aim_done,
    output logic settle_done
);
    logic [`TICK_W-1:0] step_cnt;
    logic [`TICK_W-1:0] aim_cnt;
    logic [`TICK_W-1:0] settle_cnt;
    logic [`TICK_W-1:0] step_len;
    logic               moving;

    // barrages step twice as often
    assign step_len = barrage ? `STEP_FAST : `STEP_SLOW;
    assign moving   = aiming || falling;

    // strobes fire on the last cycle of each period
    assign step_tick   = moving && (step_cnt == step_len - 1'b1);
    assign aim_done    = aiming && (aim_cnt == `AIM_TICKS - 1'b1);
    assign settle_done = settling && (settle_cnt == `SETTLE_TICKS - 1'b1);

    ////////////////////////////////////////
    // phase counters
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            step_cnt   <= '0;
            aim_cnt    <= '0;
            settle_cnt <= '0;
        end else begin
            // restart at the aim to fall boundary so the fall begins at zero
            if (!moving || aim_done || step_tick) begin
                step_cnt <= '0;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end

            if (!aiming || aim_done) begin
                aim_cnt <= '0;
            end else begin
                aim_cnt <= aim_cnt + 1'b1;
            end

            if (!settling || settle_done) begin
                settle_cnt <= '0;
            end else begin
                settle_cnt <= settle_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/spike_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spike_params.svh"

module spike_sequencer (
    input  logic       clk,
    input  logic       rst,
    input  logic       done_in,
    input  logic       play_selected,
    input  logic       menu_on,
    input  logic [2:0] selected,
    input  logic       aim_done,
    input  logic       settle_done,
    input  logic       landed,
    output logic       load_spike,
    output logic       aiming,
    output logic       falling,
    output logic       settling,
    output logic       from_bottom,
    output logic       barrage,
    output logic       done
);
    import spike_pkg::*;

    seq_state_t  state;
    seq_state_t  state_nxt;
    logic [4:0]  index;
    logic [4:0]  index_nxt;
    logic        done_nxt;
    spike_kind_t kind;
    logic        start;
    logic        abort;
    logic        last_spike;
    logic        spike_end;

    // kind of the spike in flight
    assign kind = kind_of(index);

    // previous stage finished with this obstacle picked in play mode
    assign start      = done_in && play_selected && (selected == `OBSTACLE_CODE);
    // menu or leaving play drops the attack
    assign abort      = menu_on || !play_selected;
    assign last_spike = (index == `SPIKE_COUNT - 5'd1);

    ////////////////////////////////////////
    // state register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seq_idle;
            index <= '0;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            index <= index_nxt;
            done  <= done_nxt;
        end
    end

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        index_nxt = index;
        done_nxt  = 1'b0;
        spike_end = 1'b0;
        case (state)
            seq_idle: begin
                if (start) begin
                    state_nxt = seq_load;
                    index_nxt = '0;
                end
            end
            // position module latches the launch point here
            seq_load: state_nxt = seq_aim;
            seq_aim: begin
                if (aim_done) begin
                    state_nxt = seq_fall;
                end
            end
            seq_fall: begin
                // only the plain top spike pauses after landing
                if (landed && (kind == kind_top)) begin
                    state_nxt = seq_settle;
                end else if (landed) begin
                    spike_end = 1'b1;
                end
            end
            seq_settle: spike_end = settle_done;
            default: state_nxt = seq_idle;
        endcase

        // move on to the next spike or finish the attack
        if (spike_end) begin
            if (last_spike) begin
                state_nxt = seq_idle;
                done_nxt  = 1'b1;
            end else begin
                state_nxt = seq_load;
                index_nxt = index + 5'd1;
            end
        end

        // abort wins over every phase move, no done pulse
        if (abort && (state != seq_idle)) begin
            state_nxt = seq_idle;
            done_nxt  = 1'b0;
        end
    end

    // phase levels decoded from the state
    assign load_spike  = (state == seq_load);
    assign aiming      = (state == seq_aim);
    assign falling     = (state == seq_fall);
    assign settling    = (state == seq_settle);
    assign from_bottom = (kind == kind_bottom) || (kind == kind_barrage_bottom);
    assign barrage     = (kind == kind_barrage_top) || (kind == kind_barrage_bottom);

endmodule

`default_nettype wire

/* src/spike_pkg.sv */
`default_nettype none

////////////////////////////////////////
// types of the obstacle control side
////////////////////////////////////////
package spike_pkg;

    // sequencer states
    typedef enum logic [2:0] {
        seq_idle,
        seq_load,
        seq_aim,
        seq_fall,
        seq_settle
    } seq_state_t;

    // launch edge and speed of one spike
    typedef enum logic [1:0] {
        kind_top,
        kind_bottom,
        kind_barrage_top,
        kind_barrage_bottom
    } spike_kind_t;

    // fixed launch order of the attack, index 0 to 19
    function automatic spike_kind_t kind_of(input logic [4:0] index);
        spike_kind_t kind;
        // bottom barrages are 1, 7, 10, 13, 17
        kind = kind_barrage_bottom;
        case (index)
            5'd0, 5'd4, 5'd6, 5'd12, 5'd18: kind = kind_top;
            5'd3, 5'd8, 5'd9, 5'd14, 5'd16: kind = kind_barrage_top;
            5'd2, 5'd5, 5'd11, 5'd15, 5'd19: kind = kind_bottom;
            default: kind = kind_barrage_bottom;
        endcase
        return kind;
    endfunction

endpackage

`default_nettype wire

/* src/video_pkg.sv */
`default_nettype none

////////////////////////////////////////
// types shared with the video pipeline
////////////////////////////////////////
package video_pkg;

    // pixel position, used for hcount, vcount, mouse and spike center
    typedef logic [11:0] coord_t;

    // 4 bits each of red, green, blue
    typedef logic [11:0] rgb_t;

endpackage

`default_nettype wire

/* include/spike_params.svh */
`ifndef SPIKE_PARAMS_SVH
`define SPIKE_PARAMS_SVH

////////////////////////////////////////
// playfield geometry, in pixels
////////////////////////////////////////
`define FIELD_TOP         12'd317
`define FIELD_BOTTOM      12'd617
// aim phase keeps the spike center inside these columns
`define FIELD_LEFT        12'd361
`define FIELD_RIGHT       12'd661
// every spike is launched from this column
`define FIELD_CENTER_X    12'd511

// half width of the spike, also the landing margin at the far edge
`define SPIKE_HALF_WIDTH  12'd20
// depth limit of the triangle body
`define SPIKE_LENGTH      12'd50
// bound of 3*dx + dy, sets the slope of the sides
`define SPIKE_TIP         12'd40
`define SPIKE_COUNT       5'd20

////////////////////////////////////////
// phase timing, in clock cycles
////////////////////////////////////////
`define TICK_W            26
// values for simulation, board build uses 65000000
`define AIM_TICKS         26'd400
// board build uses 300000
`define STEP_SLOW         26'd4
// board build uses 150000
`define STEP_FAST         26'd2
// board build uses 32500000
`define SETTLE_TICKS      26'd100

// 4:4:4 colors
`define COLOR_SPIKE       12'hfff
`define COLOR_WARN        12'hf00

// game code of this obstacle on the selected bus
`define OBSTACLE_CODE     3'b101

`endif
